//--- design/pwo_pkg.sv
//==========================================================
// Shared sizes, modulus and types of the pointwise engine
// Imported by every design and testbench file that needs them
//==========================================================

package pwo_pkg;

    //==========================================================
    // Memory layout
    //==========================================================

    // Coefficient value and its memory slot, top slot bit unused
    localparam int COEFF_W   = 23;
    localparam int SLOT_W    = COEFF_W + 1;

    // Four coefficients share one memory word
    localparam int LANES     = 4;
    localparam int WORD_W    = LANES * SLOT_W;

    // 256 coefficients per polynomial
    localparam int NUM_WORDS = 64;
    localparam int CNT_W     = $clog2(NUM_WORDS);
    localparam int ADDR_W    = 15;

    // Full width of a*b + c before reduction
    localparam int PROD_W    = 2 * COEFF_W;

    //==========================================================
    // Types
    //==========================================================

    typedef logic [COEFF_W-1:0] coeff_t;

    // Lane 0 sits in the lowest slot
    typedef coeff_t [LANES-1:0] coeff_vec_t;

    typedef logic [ADDR_W-1:0] addr_t;

    // Q = 2^23 - 2^13 + 1
    localparam coeff_t MOD_Q = 23'd8380417;

    typedef enum logic [1:0] {
        PWO_IDLE = 2'b00,
        PWO_PWM  = 2'b01,
        PWO_PWA  = 2'b10,
        PWO_PWS  = 2'b11
    } pwo_mode_t;

endpackage

//--- design/pwo_issue_if.sv
//==========================================================
// Stage-to-stage links of the pointwise engine
// Issue stream from decode to execute, results to the writer
//==========================================================
`timescale 1ns/1ns

// One issued word per cycle, qualified by valid
interface pwo_issue_if import pwo_pkg::*; ();
    logic      valid;
    logic      last;
    pwo_mode_t mode;
    logic      accumulate;
    addr_t     wr_addr;

    modport decode_mp  (output valid, last, mode, accumulate, wr_addr);
    modport execute_mp (input  valid, last, mode, accumulate, wr_addr);
endinterface

// Reduced results of one word
interface pwo_result_if import pwo_pkg::*; ();
    logic       valid;
    logic       last;
    addr_t      wr_addr;
    coeff_vec_t result;

    modport execute_mp (output valid, last, wr_addr, result);
    modport result_mp  (input  valid, last, wr_addr, result);
endinterface

//--- design/pwo_decode.sv
//==========================================================
// Start and busy control, word counter and read addressing
// Issues one word per cycle towards the execute stage
//==========================================================
`timescale 1ns/1ns

module pwo_decode import pwo_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize_i,
    input  logic              start_i,
    input  logic              accumulate_i,
    input  pwo_mode_t         mode_i,
    input  addr_t             a_base_i,
    input  addr_t             b_base_i,
    input  addr_t             c_base_i,
    input  logic              done_i,
    output logic              a_rd_en_o,
    output logic              b_rd_en_o,
    output logic              c_rd_en_o,
    output addr_t             a_rd_addr_o,
    output addr_t             b_rd_addr_o,
    output addr_t             c_rd_addr_o,
    output logic              busy_o,
    pwo_issue_if.decode_mp    issue
);

    logic             busy_q;
    logic             active_q;
    logic [CNT_W-1:0] cnt_q;
    pwo_mode_t        mode_q;
    logic             acc_q;
    addr_t            a_base_q;
    addr_t            b_base_q;
    addr_t            c_base_q;

    logic             start_ok;
    logic             last_word;

    // A new run may start in the cycle done is seen
    assign start_ok  = start_i && (mode_i != PWO_IDLE) && (!busy_q || done_i);
    assign last_word = (cnt_q == CNT_W'(NUM_WORDS - 1));

    //==========================================================
    // Run control
    //==========================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q   <= 1'b0;
            active_q <= 1'b0;
            cnt_q    <= '0;
            mode_q   <= PWO_IDLE;
            acc_q    <= 1'b0;
        end else if (zeroize_i) begin
            busy_q   <= 1'b0;
            active_q <= 1'b0;
            cnt_q    <= '0;
            mode_q   <= PWO_IDLE;
            acc_q    <= 1'b0;
        end else if (start_ok) begin
            busy_q   <= 1'b1;
            active_q <= 1'b1;
            cnt_q    <= '0;
            mode_q   <= mode_i;
            acc_q    <= accumulate_i;
        end else begin
            if (done_i) begin
                busy_q <= 1'b0;
            end
            if (active_q) begin
                cnt_q <= cnt_q + CNT_W'(1);
                // Stop reading after word 63
                if (last_word) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    // Base addresses held for the whole run
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            a_base_q <= '0;
            b_base_q <= '0;
            c_base_q <= '0;
        end else if (start_ok) begin
            a_base_q <= a_base_i;
            b_base_q <= b_base_i;
            c_base_q <= c_base_i;
        end
    end

    //==========================================================
    // Read port and issue stream
    //==========================================================

    assign a_rd_en_o   = active_q;
    assign b_rd_en_o   = active_q;
    // Destination is only read to accumulate into it
    assign c_rd_en_o   = active_q && (mode_q == PWO_PWM) && acc_q;

    assign a_rd_addr_o = a_base_q + addr_t'(cnt_q);
    assign b_rd_addr_o = b_base_q + addr_t'(cnt_q);
    assign c_rd_addr_o = c_base_q + addr_t'(cnt_q);

    assign busy_o      = busy_q && !done_i;

    assign issue.valid      = active_q;
    assign issue.last       = last_word;
    assign issue.mode       = mode_q;
    assign issue.accumulate = acc_q;
    assign issue.wr_addr    = c_base_q + addr_t'(cnt_q);

endmodule

//--- design/pwo_execute.sv
//==========================================================
// Four modular lanes for multiply-accumulate, add and subtract
// Two pipeline stages after the read data is lined up
//==========================================================
`timescale 1ns/1ns

module pwo_execute import pwo_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  logic [WORD_W-1:0]  a_rd_data_i,
    input  logic [WORD_W-1:0]  b_rd_data_i,
    input  logic [WORD_W-1:0]  c_rd_data_i,
    pwo_issue_if.execute_mp    issue,
    pwo_result_if.execute_mp   res
);

    // Issue fields one cycle late, in step with the read data
    logic      iss_valid_q;
    logic      iss_last_q;
    logic      iss_acc_q;
    pwo_mode_t iss_mode_q;
    addr_t     iss_addr_q;

    coeff_vec_t a_vec;
    coeff_vec_t b_vec;
    coeff_vec_t c_vec;
    logic [LANES-1:0][SLOT_W-1:0] sum_d;
    logic [LANES-1:0][SLOT_W-1:0] diff_d;
    logic [LANES-1:0][PROD_W-1:0] raw_d;

    logic      s1_valid_q;
    logic      s1_last_q;
    pwo_mode_t s1_mode_q;
    addr_t     s1_addr_q;
    logic [LANES-1:0][PROD_W-1:0] s1_raw_q;

    coeff_vec_t red_d;

    //==========================================================
    // Reduction helpers
    //==========================================================

    // Folds the top bits with 2^23 = 2^13 - 1 (mod Q), three times
    function automatic coeff_t reduce_mul(input logic [PROD_W-1:0] x);
        logic [35:0]       t1;
        logic [26:0]       t2;
        logic [SLOT_W-1:0] t3;
        t1 = {x[PROD_W-1:COEFF_W], 13'd0} - 36'(x[PROD_W-1:COEFF_W])
             + 36'(x[COEFF_W-1:0]);
        t2 = {t1[35:23], 13'd0} - 27'(t1[35:23]) + 27'(t1[22:0]);
        t3 = {t2[26:23], 13'd0} - 24'(t2[26:23]) + 24'(t2[22:0]);
        // t3 is below 2Q here
        if (t3 >= {1'b0, MOD_Q}) begin
            t3 = t3 - {1'b0, MOD_Q};
        end
        return t3[COEFF_W-1:0];
    endfunction

    function automatic coeff_t reduce_add(input logic [SLOT_W-1:0] s);
        logic [SLOT_W-1:0] r;
        r = (s >= {1'b0, MOD_Q}) ? s - {1'b0, MOD_Q} : s;
        return r[COEFF_W-1:0];
    endfunction

    // Borrow in the top bit means a < b
    function automatic coeff_t reduce_sub(input logic [SLOT_W-1:0] d);
        logic [SLOT_W-1:0] r;
        r = d[SLOT_W-1] ? d + {1'b0, MOD_Q} : d;
        return r[COEFF_W-1:0];
    endfunction

    //==========================================================
    // Stage 1 raw sum, difference or product
    //==========================================================

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            a_vec[i]  = a_rd_data_i[i*SLOT_W +: COEFF_W];
            b_vec[i]  = b_rd_data_i[i*SLOT_W +: COEFF_W];
            c_vec[i]  = (iss_mode_q == PWO_PWM && iss_acc_q) ?
                        c_rd_data_i[i*SLOT_W +: COEFF_W] : '0;
            sum_d[i]  = {1'b0, a_vec[i]} + {1'b0, b_vec[i]};
            diff_d[i] = {1'b0, a_vec[i]} - {1'b0, b_vec[i]};
            case (iss_mode_q)
                PWO_PWM: raw_d[i] = PROD_W'(a_vec[i]) * PROD_W'(b_vec[i]) + PROD_W'(c_vec[i]);
                PWO_PWA: raw_d[i] = PROD_W'(sum_d[i]);
                PWO_PWS: raw_d[i] = PROD_W'(diff_d[i]);
                default: raw_d[i] = '0;
            endcase
        end
    end

    //==========================================================
    // Stage 2 reduction
    //==========================================================

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            case (s1_mode_q)
                PWO_PWM: red_d[i] = reduce_mul(s1_raw_q[i]);
                PWO_PWA: red_d[i] = reduce_add(s1_raw_q[i][SLOT_W-1:0]);
                PWO_PWS: red_d[i] = reduce_sub(s1_raw_q[i][SLOT_W-1:0]);
                default: red_d[i] = '0;
            endcase
        end
    end

    // Valid pipeline
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            iss_valid_q <= 1'b0;
            s1_valid_q  <= 1'b0;
            res.valid   <= 1'b0;
        end else if (zeroize_i) begin
            iss_valid_q <= 1'b0;
            s1_valid_q  <= 1'b0;
            res.valid   <= 1'b0;
        end else begin
            iss_valid_q <= issue.valid;
            s1_valid_q  <= iss_valid_q;
            res.valid   <= s1_valid_q;
        end
    end

    // Word fields and lane data
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            iss_last_q  <= 1'b0;
            iss_acc_q   <= 1'b0;
            iss_mode_q  <= PWO_IDLE;
            iss_addr_q  <= '0;
            s1_last_q   <= 1'b0;
            s1_mode_q   <= PWO_IDLE;
            s1_addr_q   <= '0;
            s1_raw_q    <= '0;
            res.last    <= 1'b0;
            res.wr_addr <= '0;
            res.result  <= '0;
        end else begin
            iss_last_q  <= issue.last;
            iss_acc_q   <= issue.accumulate;
            iss_mode_q  <= issue.mode;
            iss_addr_q  <= issue.wr_addr;
            s1_last_q   <= iss_last_q;
            s1_mode_q   <= iss_mode_q;
            s1_addr_q   <= iss_addr_q;
            s1_raw_q    <= raw_d;
            res.last    <= s1_last_q;
            res.wr_addr <= s1_addr_q;
            res.result  <= red_d;
        end
    end

endmodule

//--- design/pwo_result.sv
//==========================================================
// Destination write port and completion pulse
// Packs reduced lanes into memory slots, one word per cycle
//==========================================================
`timescale 1ns/1ns

module pwo_result import pwo_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize_i,
    pwo_result_if.result_mp   res,
    output logic              c_wr_en_o,
    output addr_t             c_wr_addr_o,
    output logic [WORD_W-1:0] c_wr_data_o,
    output logic              done_o
);

    logic              wr_last_q;
    logic [WORD_W-1:0] wr_data_d;

    // Top bit of every slot written as zero
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            wr_data_d[i*SLOT_W +: SLOT_W] = {1'b0, res.result[i]};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            c_wr_en_o <= 1'b0;
            wr_last_q <= 1'b0;
            done_o    <= 1'b0;
        end else if (zeroize_i) begin
            c_wr_en_o <= 1'b0;
            wr_last_q <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            c_wr_en_o <= res.valid;
            wr_last_q <= res.valid && res.last;
            // One cycle after the last write
            done_o    <= wr_last_q;
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            c_wr_addr_o <= '0;
            c_wr_data_o <= '0;
        end else if (res.valid) begin
            c_wr_addr_o <= res.wr_addr;
            c_wr_data_o <= wr_data_d;
        end
    end

endmodule

//--- design/pwo_top.sv
//==========================================================
// Pointwise polynomial engine top level, modulus 8380417
// Plain memory and control ports, one polynomial per start
//==========================================================
`timescale 1ns/1ns

module pwo_top import pwo_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize_i,
    input  logic              start_i,
    input  logic              accumulate_i,
    input  pwo_mode_t         mode_i,
    input  addr_t             a_base_i,
    input  addr_t             b_base_i,
    input  addr_t             c_base_i,
    // Operand and accumulator reads, data one cycle after enable
    input  logic [WORD_W-1:0] a_rd_data_i,
    input  logic [WORD_W-1:0] b_rd_data_i,
    input  logic [WORD_W-1:0] c_rd_data_i,
    output logic              a_rd_en_o,
    output logic              b_rd_en_o,
    output logic              c_rd_en_o,
    output addr_t             a_rd_addr_o,
    output addr_t             b_rd_addr_o,
    output addr_t             c_rd_addr_o,
    // Destination writes
    output logic              c_wr_en_o,
    output addr_t             c_wr_addr_o,
    output logic [WORD_W-1:0] c_wr_data_o,
    output logic              busy_o,
    output logic              done_o
);

    pwo_issue_if  issue_if ();
    pwo_result_if res_if ();

    pwo_decode u_decode (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .start_i      (start_i),
        .accumulate_i (accumulate_i),
        .mode_i       (mode_i),
        .a_base_i     (a_base_i),
        .b_base_i     (b_base_i),
        .c_base_i     (c_base_i),
        .done_i       (done_o),
        .a_rd_en_o    (a_rd_en_o),
        .b_rd_en_o    (b_rd_en_o),
        .c_rd_en_o    (c_rd_en_o),
        .a_rd_addr_o  (a_rd_addr_o),
        .b_rd_addr_o  (b_rd_addr_o),
        .c_rd_addr_o  (c_rd_addr_o),
        .busy_o       (busy_o),
        .issue        (issue_if.decode_mp)
    );

    pwo_execute u_execute (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .a_rd_data_i (a_rd_data_i),
        .b_rd_data_i (b_rd_data_i),
        .c_rd_data_i (c_rd_data_i),
        .issue       (issue_if.execute_mp),
        .res         (res_if.execute_mp)
    );

    pwo_result u_result (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .res         (res_if.result_mp),
        .c_wr_en_o   (c_wr_en_o),
        .c_wr_addr_o (c_wr_addr_o),
        .c_wr_data_o (c_wr_data_o),
        .done_o      (done_o)
    );

endmodule

//--- sim/pwo_tb_check.svh
//==========================================================
// Testbench helpers for the pointwise engine
// Random coefficients, reference arithmetic and typed compares
//==========================================================
`ifndef PWO_TB_CHECK_SVH
`define PWO_TB_CHECK_SVH

// Galois LFSR, one step per bit taken
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'hB4BC_D35C;
    end
    return s >> 1;
endfunction

// 23 random bits folded below Q
task automatic rand_coeff(output coeff_t v);
    v = '0;
    for (int n = 0; n < COEFF_W; n++) begin
        v = {v[COEFF_W-2:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    if (v >= MOD_Q) begin
        v = v - MOD_Q;
    end
endtask

// Expected coefficient straight from the modular rules
function automatic coeff_t ref_pointwise(input pwo_mode_t m, input logic acc,
                                         input coeff_t a, input coeff_t b, input coeff_t c);
    longint q;
    longint r;
    q = longint'(MOD_Q);
    case (m)
        PWO_PWM: r = (longint'(a) * longint'(b) + (acc ? longint'(c) : longint'(0))) % q;
        PWO_PWA: r = (longint'(a) + longint'(b)) % q;
        PWO_PWS: r = (longint'(a) - longint'(b) + q) % q;
        default: r = 0;
    endcase
    return coeff_t'(r);
endfunction

task automatic compare_coeff(input coeff_t got, input coeff_t exp, input string what);
    if (got !== exp) begin
        coeff_errs++;
        $display("ERROR at %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic compare_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
        addr_errs++;
        $display("ERROR at %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
    end
endtask

task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        ctrl_errs++;
        $display("ERROR at %0t ns: %s: got %b, expected %b", $time, what, got, exp);
    end
endtask

`endif

//--- sim/pwo_tb.sv
//==========================================================
// Testbench for the pointwise engine, one run per tests line
// Memory models with one cycle read latency, every write checked
//==========================================================
`timescale 1ns/1ns

module pwo_tb import pwo_pkg::*; ();

    localparam int MEM_DEPTH = 256;
    localparam int MAX_BASE  = MEM_DEPTH - NUM_WORDS;

    logic              clk;
    logic              reset_n      = 1'b0;
    logic              zeroize_i    = 1'b0;
    logic              start_i      = 1'b0;
    logic              accumulate_i = 1'b0;
    pwo_mode_t         mode_i       = PWO_IDLE;
    addr_t             a_base_i     = '0;
    addr_t             b_base_i     = '0;
    addr_t             c_base_i     = '0;
    logic [WORD_W-1:0] a_rd_data_i  = '0;
    logic [WORD_W-1:0] b_rd_data_i  = '0;
    logic [WORD_W-1:0] c_rd_data_i  = '0;
    logic              a_rd_en_o;
    logic              b_rd_en_o;
    logic              c_rd_en_o;
    addr_t             a_rd_addr_o;
    addr_t             b_rd_addr_o;
    addr_t             c_rd_addr_o;
    logic              c_wr_en_o;
    addr_t             c_wr_addr_o;
    logic [WORD_W-1:0] c_wr_data_o;
    logic              busy_o;
    logic              done_o;

    logic [WORD_W-1:0] a_mem [MEM_DEPTH];
    logic [WORD_W-1:0] b_mem [MEM_DEPTH];
    logic [WORD_W-1:0] c_mem [MEM_DEPTH];
    logic              a_pend = 1'b0;
    logic              b_pend = 1'b0;
    logic              c_pend = 1'b0;
    addr_t             a_pend_addr = '0;
    addr_t             b_pend_addr = '0;
    addr_t             c_pend_addr = '0;

    // Test table from the tests file
    pwo_mode_t t_mode [$];
    logic      t_acc [$];
    int        t_ctl [$];
    coeff_t    t_a [$];
    coeff_t    t_b [$];
    coeff_t    t_c [$];
    coeff_t    t_exp [$];
    int        n_tests        = 0;
    logic      tests_loaded   = 1'b0;
    int        timeout_cycles = 0;
    int        cycle_cnt      = 0;

    // Expectations of the current run
    addr_t      a_base;
    addr_t      b_base;
    addr_t      c_base;
    logic       exp_c_rd;
    coeff_vec_t exp_vec [NUM_WORDS];
    int         rd_cyc [NUM_WORDS];
    int         rd_cnt      = 0;
    int         wr_cnt      = 0;
    int         done_cnt    = 0;
    int         last_wr_cyc = 0;
    int         mon_cyc     = 0;

    int          coeff_errs = 0;
    int          addr_errs  = 0;
    int          ctrl_errs  = 0;
    int          other_errs = 0;
    logic [31:0] lfsr_state = 32'h3c37;

    `include "pwo_tb_check.svh"

    pwo_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //==========================================================
    // Memory models and write monitor
    //==========================================================

    // Data for the enable seen one cycle earlier
    always @(negedge clk) begin
        if (a_pend) a_rd_data_i = a_mem[a_pend_addr[7:0]];
        if (b_pend) b_rd_data_i = b_mem[b_pend_addr[7:0]];
        if (c_pend) c_rd_data_i = c_mem[c_pend_addr[7:0]];
        a_pend      = a_rd_en_o;
        b_pend      = b_rd_en_o;
        c_pend      = c_rd_en_o;
        a_pend_addr = a_rd_addr_o;
        b_pend_addr = b_rd_addr_o;
        c_pend_addr = c_rd_addr_o;
        if (c_wr_en_o) c_mem[c_wr_addr_o[7:0]] = c_wr_data_o;
    end

    always @(negedge clk) begin
        mon_cyc++;
        if (a_rd_en_o) begin
            if (rd_cnt < NUM_WORDS) begin
                compare_addr(a_rd_addr_o, a_base + addr_t'(rd_cnt), "a read address");
                compare_addr(b_rd_addr_o, b_base + addr_t'(rd_cnt), "b read address");
                compare_bit(b_rd_en_o, 1'b1, "b read enable");
                compare_bit(c_rd_en_o, exp_c_rd, "c read enable");
                if (exp_c_rd) begin
                    compare_addr(c_rd_addr_o, c_base + addr_t'(rd_cnt), "c read address");
                end
                if (rd_cnt > 0) begin
                    compare_bit(mon_cyc == rd_cyc[rd_cnt-1] + 1, 1'b1, "reads back to back");
                end
                rd_cyc[rd_cnt] = mon_cyc;
            end else begin
                $display("Read beyond the last word at %0t ns", $time);
                other_errs++;
            end
            rd_cnt++;
        end else begin
            compare_bit(b_rd_en_o, 1'b0, "b read enable while idle");
            compare_bit(c_rd_en_o, 1'b0, "c read enable while idle");
        end
        if (a_rd_en_o || c_wr_en_o) begin
            compare_bit(busy_o, 1'b1, "busy during a transfer");
        end
        if (c_wr_en_o) begin
            if (wr_cnt < NUM_WORDS && wr_cnt < rd_cnt) begin
                compare_addr(c_wr_addr_o, c_base + addr_t'(wr_cnt), "write address");
                compare_bit(mon_cyc == rd_cyc[wr_cnt] + 4, 1'b1,
                            $sformatf("write %0d four cycles after its read", wr_cnt));
                for (int i = 0; i < LANES; i++) begin
                    compare_coeff(c_wr_data_o[i*SLOT_W +: COEFF_W], exp_vec[wr_cnt][i],
                                  $sformatf("word %0d lane %0d", wr_cnt, i));
                    compare_bit(c_wr_data_o[i*SLOT_W + COEFF_W], 1'b0, "slot top bit");
                end
                last_wr_cyc = mon_cyc;
            end else begin
                $display("Unexpected write to address %0d at %0t ns", c_wr_addr_o, $time);
                other_errs++;
            end
            wr_cnt++;
        end
        if (done_o) begin
            done_cnt++;
            compare_bit(busy_o, 1'b0, "busy with done");
            compare_bit(wr_cnt == NUM_WORDS && last_wr_cyc == mon_cyc - 1, 1'b1,
                        "done one cycle after the last write");
        end
    end

    // Cycle limit from the number of tests
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (tests_loaded && cycle_cnt >= timeout_cycles) begin
            $display("Timeout, the tests did not finish within %0d cycles", timeout_cycles);
            report_counts();
            $display("=== FAIL ===");
            $finish;
        end
    end

    //==========================================================
    // Test sequencing
    //==========================================================

    function automatic int error_total();
        return coeff_errs + addr_errs + ctrl_errs + other_errs;
    endfunction

    task automatic report_counts();
        $display("Errors: coefficient %0d, address %0d, control %0d, other %0d",
                 coeff_errs, addr_errs, ctrl_errs, other_errs);
    endtask

    task automatic load_tests();
        int    fd;
        string line;
        int    m, acc, ctl, a, b, c, e;
        fd = $fopen("sim/pwo_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the tests file sim/pwo_tests.txt");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Comment and blank lines do not parse
                if ($sscanf(line, "%d %d %d %d %d %d %d", m, acc, ctl, a, b, c, e) == 7) begin
                    t_mode.push_back(pwo_mode_t'(m[1:0]));
                    t_acc.push_back(acc[0]);
                    t_ctl.push_back(ctl);
                    t_a.push_back(coeff_t'(a));
                    t_b.push_back(coeff_t'(b));
                    t_c.push_back(coeff_t'(c));
                    t_exp.push_back(coeff_t'(e));
                end
            end
            $fclose(fd);
        end
        n_tests = t_mode.size();
        if (n_tests == 0) begin
            $display("No tests were found in the tests file");
            other_errs++;
        end
        timeout_cycles = n_tests * 100 + 50;
        tests_loaded   = 1'b1;
    endtask

    // Random memories, directed coefficient 0 and expected words
    task automatic prepare_run(input int t);
        coeff_t v;
        coeff_t a;
        coeff_t b;
        coeff_t c;
        for (int w = 0; w < MEM_DEPTH; w++) begin
            for (int i = 0; i < LANES; i++) begin
                rand_coeff(v);
                a_mem[w][i*SLOT_W +: SLOT_W] = {1'b0, v};
                rand_coeff(v);
                b_mem[w][i*SLOT_W +: SLOT_W] = {1'b0, v};
                rand_coeff(v);
                c_mem[w][i*SLOT_W +: SLOT_W] = {1'b0, v};
            end
        end
        a_base = addr_t'((t * 37) % (MAX_BASE + 1));
        b_base = addr_t'((t * 53 + 11) % (MAX_BASE + 1));
        c_base = addr_t'((t * 71 + 23) % (MAX_BASE + 1));
        a_mem[a_base][COEFF_W-1:0] = t_a[t];
        b_mem[b_base][COEFF_W-1:0] = t_b[t];
        c_mem[c_base][COEFF_W-1:0] = t_c[t];
        exp_c_rd = (t_mode[t] == PWO_PWM) && t_acc[t];
        for (int k = 0; k < NUM_WORDS; k++) begin
            for (int i = 0; i < LANES; i++) begin
                a = a_mem[a_base + k][i*SLOT_W +: COEFF_W];
                b = b_mem[b_base + k][i*SLOT_W +: COEFF_W];
                c = c_mem[c_base + k][i*SLOT_W +: COEFF_W];
                exp_vec[k][i] = ref_pointwise(t_mode[t], t_acc[t], a, b, c);
            end
        end
        exp_vec[0][0] = t_exp[t];
        rd_cnt      = 0;
        wr_cnt      = 0;
        done_cnt    = 0;
        last_wr_cyc = 0;
    endtask

    task automatic start_run(input int t);
        mode_i       = t_mode[t];
        accumulate_i = t_acc[t];
        a_base_i     = a_base;
        b_base_i     = b_base;
        c_base_i     = c_base;
        start_i      = 1'b1;
        @(negedge clk);
        start_i = 1'b0;
    endtask

    task automatic finish_run();
        do begin
            @(negedge clk);
        end while (!done_o);
        @(negedge clk);
        compare_bit(rd_cnt == NUM_WORDS, 1'b1, $sformatf("%0d reads in the run", rd_cnt));
        compare_bit(wr_cnt == NUM_WORDS, 1'b1, $sformatf("%0d writes in the run", wr_cnt));
        compare_bit(done_cnt == 1, 1'b1, $sformatf("%0d done pulses", done_cnt));
    endtask

    task automatic run_test(input int t);
        int writes_before;
        prepare_run(t);
        start_run(t);
        if (t_ctl[t] == 1) begin
            // Start with other settings while busy
            repeat (20) @(negedge clk);
            mode_i       = (t_mode[t] == PWO_PWM) ? PWO_PWA : PWO_PWM;
            accumulate_i = 1'b1;
            a_base_i     = a_base + addr_t'(1);
            b_base_i     = b_base + addr_t'(2);
            c_base_i     = c_base + addr_t'(3);
            start_i      = 1'b1;
            @(negedge clk);
            start_i = 1'b0;
        end else if (t_ctl[t] == 2) begin
            repeat (10) @(negedge clk);
            zeroize_i = 1'b1;
            @(negedge clk);
            zeroize_i = 1'b0;
            compare_bit(a_rd_en_o, 1'b0, "a read enable after zeroize");
            compare_bit(b_rd_en_o, 1'b0, "b read enable after zeroize");
            compare_bit(c_rd_en_o, 1'b0, "c read enable after zeroize");
            compare_bit(c_wr_en_o, 1'b0, "write enable after zeroize");
            compare_bit(busy_o, 1'b0, "busy after zeroize");
            compare_bit(done_o, 1'b0, "done after zeroize");
            writes_before = wr_cnt;
            repeat (6) @(negedge clk);
            compare_bit(wr_cnt == writes_before && done_cnt == 0, 1'b1,
                        "no writes or done after zeroize");
            prepare_run(t);
            start_run(t);
        end
        finish_run();
    endtask

    initial begin
        load_tests();
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        report_counts();
        if (error_total() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+sim
design/pwo_pkg.sv
design/pwo_issue_if.sv
design/pwo_decode.sv
design/pwo_execute.sv
design/pwo_result.sv
design/pwo_top.sv
sim/pwo_tb.sv

//--- Makefile
# Verilator build and run of the pointwise engine testbench

SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := pwo_tb
FILELIST := src.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output is shown, then searched for the pass message
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/pwo_tests.txt
# Pointwise engine tests, one run per line, decimal values, Q = 8380417
# mode (1 PWM, 2 PWA, 3 PWS), acc, ctl (0 plain, 1 start while busy, 2 zeroize)
# then a0 b0 c0 of coefficient 0 and its expected result
1 0 0 2 3 77 6
1 0 0 8380416 8380416 0 1
1 0 0 8380416 2 0 8380415
1 0 0 4194304 4 0 16382
1 1 0 8380416 8380416 8380416 0
1 1 1 1000 1000 5 1000005
1 1 0 0 12345 8380416 8380416
1 0 2 3 3 0 9
2 0 0 8380416 1 0 0
2 0 0 8380416 8380416 0 8380415
2 0 2 100 200 0 300
2 1 0 5 6 9 11
3 0 0 5 7 0 8380415
3 0 0 4242 4242 0 0
3 0 1 0 8380416 0 1
3 0 0 8380416 0 0 8380416
